// ==== src/vrc3_pkg.sv ====
`default_nettype none

package vrc3_pkg;

	typedef logic [7:0]  byte_t;       // Data byte on either bus.
	typedef logic [3:0]  nibble_t;     // Bank number or one reload digit.
	typedef logic [15:0] cpu_addr_t;
	typedef logic [13:0] ppu_addr_t;
	typedef logic [17:0] prg_addr_t;   // 256 KB of PRG ROM.
	typedef logic [12:0] srm_addr_t;   // 8 KB of save RAM.
	typedef logic [12:0] chr_addr_t;   // 8 KB of CHR.
	typedef logic [15:0] irq_count_t;
	typedef logic [7:0]  sst_addr_t;

	// Counter width, control bit 2.
	typedef enum logic {
		IRQ_W16 = 1'b0,
		IRQ_W8  = 1'b1
	} irq_width_t;

	// Register windows, 4 KB each.
	localparam cpu_addr_t REG_LATCH0   = 16'h8000;   // Reload bits 3:0.
	localparam cpu_addr_t REG_LATCH1   = 16'h9000;   // Reload bits 7:4.
	localparam cpu_addr_t REG_LATCH2   = 16'hA000;   // Reload bits 11:8.
	localparam cpu_addr_t REG_LATCH3   = 16'hB000;   // Reload bits 15:12.
	localparam cpu_addr_t REG_IRQ_CTRL = 16'hC000;
	localparam cpu_addr_t REG_IRQ_ACK  = 16'hD000;
	localparam cpu_addr_t REG_PRG_BANK = 16'hF000;

	localparam cpu_addr_t SRM_BASE      = 16'h6000;
	localparam nibble_t   PRG_LAST_BANK = 4'd15;

	// Save-state register indices.
	localparam sst_addr_t SST_PRG       = 8'd0;
	localparam sst_addr_t SST_IRQ_CTRL  = 8'd1;
	localparam sst_addr_t SST_RELOAD_HI = 8'd2;
	localparam sst_addr_t SST_RELOAD_LO = 8'd3;
	localparam sst_addr_t SST_COUNT_HI  = 8'd4;
	localparam sst_addr_t SST_COUNT_LO  = 8'd5;
	localparam sst_addr_t SST_MAP_IDX   = 8'd127;
	localparam byte_t     SST_EMPTY     = 8'hff;

endpackage

`default_nettype wire

// ==== src/vrc3_reg_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module vrc3_reg_decode (
	input  wire                  m2,
	input  wire                  rst_n,
	input  vrc3_pkg::cpu_addr_t  cpu_addr,
	input  vrc3_pkg::byte_t      cpu_data,
	input  wire                  cpu_rw,
	input  wire                  sst_act,
	input  wire                  sst_we_reg,
	input  vrc3_pkg::sst_addr_t  sst_addr,
	input  vrc3_pkg::byte_t      sst_dato,
	output logic [3:0]           latch_we,
	output logic                 ctrl_we,
	output logic                 ack_we,
	output vrc3_pkg::nibble_t    wdata,
	output vrc3_pkg::nibble_t    prg_bank
);
	import vrc3_pkg::*;

	cpu_addr_t reg_win;
	logic      cpu_wr;
	logic      prg_we;
	logic      sst_prg_we;

	// Only A15..A12 matter for the register windows.
	assign reg_win = {cpu_addr[15:12], 12'h000};
	assign cpu_wr  = !cpu_rw && !sst_act;   // Save-state mode owns the bus.

	assign latch_we[0] = cpu_wr && (reg_win == REG_LATCH0);
	assign latch_we[1] = cpu_wr && (reg_win == REG_LATCH1);
	assign latch_we[2] = cpu_wr && (reg_win == REG_LATCH2);
	assign latch_we[3] = cpu_wr && (reg_win == REG_LATCH3);
	assign ctrl_we     = cpu_wr && (reg_win == REG_IRQ_CTRL);
	assign ack_we      = cpu_wr && (reg_win == REG_IRQ_ACK);
	assign prg_we      = cpu_wr && (reg_win == REG_PRG_BANK);

	// All registers take the low nibble only.
	assign wdata = cpu_data[3:0];

	assign sst_prg_we = sst_act && sst_we_reg && (sst_addr == SST_PRG);

	always_ff @(negedge m2 or negedge rst_n)
	begin
		if (!rst_n)
		begin
			prg_bank <= '0;
		end
		else if (sst_prg_we)
		begin
			prg_bank <= sst_dato[3:0];   // Restore from save state.
		end
		else if (prg_we)
		begin
			prg_bank <= wdata;
		end
	end

	// One CPU write hits one register, never more.
	a_one_strobe : assert property (
		@(negedge m2) disable iff (!rst_n)
		$onehot0({latch_we, ctrl_we, ack_we, prg_we, sst_prg_we})
	);

endmodule

`default_nettype wire

// ==== src/vrc3_irq_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module vrc3_irq_timer (
	input  wire                   m2,
	input  wire                   rst_n,
	input  wire  [3:0]            latch_we,
	input  wire                   ctrl_we,
	input  wire                   ack_we,
	input  vrc3_pkg::nibble_t     wdata,
	input  wire                   sst_act,
	input  wire                   sst_we_reg,
	input  vrc3_pkg::sst_addr_t   sst_addr,
	input  vrc3_pkg::byte_t       sst_dato,
	output vrc3_pkg::irq_count_t  reload,
	output vrc3_pkg::irq_count_t  count,
	output logic [2:0]            irq_cfg,
	output logic                  irq_pend,
	output logic                  irq
);
	import vrc3_pkg::*;

	irq_width_t irq_mode;     // Control bit 2.
	logic       irq_on;       // Control bit 1, counter running.
	logic       irq_ack_on;   // Control bit 0, copied to irq_on on acknowledge.
	logic       sst_wr;
	logic       sst_cnt_we;
	logic       cnt_wrap;
	irq_count_t count_next;

	assign irq_cfg = {irq_mode, irq_on, irq_ack_on};
	assign irq     = irq_pend;

	assign sst_wr     = sst_act && sst_we_reg;
	assign sst_cnt_we = sst_wr && (sst_addr == SST_COUNT_HI || sst_addr == SST_COUNT_LO);

	// In 8-bit mode the high byte is left alone.
	always_comb
	begin
		if (irq_mode == IRQ_W8)
		begin
			cnt_wrap   = (count[7:0] == 8'hff);
			count_next = {count[15:8], cnt_wrap ? reload[7:0] : count[7:0] + 8'd1};
		end
		else
		begin
			cnt_wrap   = (count == 16'hffff);
			count_next = cnt_wrap ? reload : count + 16'd1;
		end
	end

	always_ff @(negedge m2 or negedge rst_n)
	begin
		if (!rst_n)
		begin
			reload     <= '0;
			count      <= '0;
			irq_mode   <= IRQ_W16;
			irq_on     <= 1'b0;
			irq_ack_on <= 1'b0;
			irq_pend   <= 1'b0;
		end
		else if (sst_act)
		begin
			// Frozen here, only restores.
			if (sst_wr && sst_addr == SST_IRQ_CTRL)
			begin
				irq_pend   <= sst_dato[3];
				irq_mode   <= irq_width_t'(sst_dato[2]);
				irq_on     <= sst_dato[1];
				irq_ack_on <= sst_dato[0];
			end
			if (sst_wr && sst_addr == SST_RELOAD_HI) reload[15:8] <= sst_dato;
			if (sst_wr && sst_addr == SST_RELOAD_LO) reload[7:0]  <= sst_dato;
			if (sst_wr && sst_addr == SST_COUNT_HI)  count[15:8]  <= sst_dato;
			if (sst_wr && sst_addr == SST_COUNT_LO)  count[7:0]   <= sst_dato;
		end
		else
		begin
			for (int i = 0; i < 4; i++)
			begin
				if (latch_we[i])
					reload[i*4 +: 4] <= wdata;
			end
			if (ack_we)
			begin
				irq_pend <= 1'b0;
				irq_on   <= irq_ack_on;
			end
			if (ctrl_we)
			begin
				irq_pend   <= 1'b0;
				irq_mode   <= irq_width_t'(wdata[2]);
				irq_on     <= wdata[1];
				irq_ack_on <= wdata[0];
				if (wdata[1])
					count <= reload;   // Start from the latch.
			end
			else if (irq_on)
			begin
				count <= count_next;
				if (cnt_wrap)
					irq_pend <= 1'b1;   // Wins over an acknowledge on the same edge.
			end
		end
	end

	a_ctrl_clears_pend : assert property (
		@(negedge m2) disable iff (!rst_n)
		ctrl_we |=> !irq_pend
	);

	a_hold_when_off : assert property (
		@(negedge m2) disable iff (!rst_n)
		(!irq_on && !ctrl_we && !sst_cnt_we) |=> $stable(count)
	);

endmodule

`default_nettype wire

// ==== src/vrc3_bank_map.sv ====
`timescale 1ns/1ps
`default_nettype none

module vrc3_bank_map (
	input  vrc3_pkg::nibble_t    prg_bank,
	input  vrc3_pkg::cpu_addr_t  cpu_addr,
	input  wire                  cpu_rw,
	input  vrc3_pkg::ppu_addr_t  ppu_addr,
	input  wire                  ppu_oe,        // Active low.
	input  wire                  ppu_we,        // Active low.
	input  wire                  cfg_mir_v,
	input  wire                  cfg_chr_ram,
	input  vrc3_pkg::byte_t      prg_do,
	input  vrc3_pkg::byte_t      srm_do,
	input  vrc3_pkg::byte_t      chr_do,
	output vrc3_pkg::prg_addr_t  prg_addr,
	output logic                 prg_ce,
	output logic                 prg_oe,
	output vrc3_pkg::srm_addr_t  srm_addr,
	output logic                 srm_ce,
	output logic                 srm_oe,
	output logic                 srm_we,
	output vrc3_pkg::chr_addr_t  chr_addr,
	output logic                 chr_ce,
	output logic                 chr_oe,
	output logic                 chr_we,
	output logic                 ciram_a10,
	output logic                 ciram_ce,
	output logic                 map_cpu_oe,
	output vrc3_pkg::byte_t      map_cpu_do,
	output logic                 map_ppu_oe,
	output vrc3_pkg::byte_t      map_ppu_do
);
	import vrc3_pkg::*;

	nibble_t prg_page;

	// PRG ROM from 8000h, upper 16 KB fixed.
	assign prg_page = cpu_addr[14] ? PRG_LAST_BANK : prg_bank;
	assign prg_addr = {prg_page, cpu_addr[13:0]};
	assign prg_ce   = cpu_addr[15];
	assign prg_oe   = cpu_rw;

	// Save RAM, 6000h to 7FFFh.
	assign srm_addr = cpu_addr[12:0];
	assign srm_ce   = ({cpu_addr[15:13], 13'd0} == SRM_BASE);
	assign srm_oe   = cpu_rw;
	assign srm_we   = !cpu_rw;

	// Pattern tables below 2000h.
	assign chr_addr = ppu_addr[12:0];
	assign chr_ce   = !ppu_addr[13];
	assign chr_oe   = !ppu_oe;
	assign chr_we   = cfg_chr_ram && !ppu_we && chr_ce;   // ROM ignores writes.

	// A10 for vertical mirroring, A11 for horizontal.
	assign ciram_a10 = cfg_mir_v ? ppu_addr[10] : ppu_addr[11];
	assign ciram_ce  = !ppu_addr[13];   // Active low, off while CHR is selected.

	assign map_cpu_oe = (srm_ce && srm_oe) || (prg_ce && prg_oe);
	assign map_cpu_do = srm_ce ? srm_do : prg_do;

	assign map_ppu_oe = chr_ce && chr_oe;
	assign map_ppu_do = map_ppu_oe ? chr_do : 8'h00;

	// Decode ranges must not overlap.
	always_comb
	begin
		a_ce_excl : assert final (!(prg_ce && srm_ce));
	end

endmodule

`default_nettype wire

// ==== src/vrc3_sst_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module vrc3_sst_port (
	input  vrc3_pkg::sst_addr_t   sst_addr,
	input  vrc3_pkg::nibble_t     prg_bank,
	input  wire                   irq_pend,
	input  wire  [2:0]            irq_cfg,
	input  vrc3_pkg::irq_count_t  reload,
	input  vrc3_pkg::irq_count_t  count,
	input  vrc3_pkg::byte_t       map_idx,
	output vrc3_pkg::byte_t       sst_di
);
	import vrc3_pkg::*;

	// Readback for the save-state engine.
	always_comb
	begin
		case (sst_addr)
			SST_PRG:
				sst_di = {4'h0, prg_bank};
			SST_IRQ_CTRL:
				sst_di = {4'h0, irq_pend, irq_cfg};   // Pending sits above the control bits.
			SST_RELOAD_HI:
				sst_di = reload[15:8];
			SST_RELOAD_LO:
				sst_di = reload[7:0];
			SST_COUNT_HI:
				sst_di = count[15:8];
			SST_COUNT_LO:
				sst_di = count[7:0];
			SST_MAP_IDX:
				sst_di = map_idx;   // Mapper number from the loader.
			default:
				sst_di = SST_EMPTY;
		endcase
	end

endmodule

`default_nettype wire

// ==== src/vrc3_mapper.sv ====
`timescale 1ns/1ps
`default_nettype none

module vrc3_mapper (
	input  wire                  m2,
	input  wire                  rst_n,
	input  vrc3_pkg::cpu_addr_t  cpu_addr,
	input  vrc3_pkg::byte_t      cpu_data,
	input  wire                  cpu_rw,
	input  vrc3_pkg::ppu_addr_t  ppu_addr,
	input  wire                  ppu_oe,
	input  wire                  ppu_we,
	input  wire                  cfg_mir_v,
	input  wire                  cfg_chr_ram,
	input  vrc3_pkg::byte_t      map_idx,
	input  wire                  sst_act,
	input  wire                  sst_we_reg,
	input  vrc3_pkg::sst_addr_t  sst_addr,
	input  vrc3_pkg::byte_t      sst_dato,
	input  vrc3_pkg::byte_t      prg_do,
	input  vrc3_pkg::byte_t      srm_do,
	input  vrc3_pkg::byte_t      chr_do,
	output vrc3_pkg::prg_addr_t  prg_addr,
	output logic                 prg_ce,
	output logic                 prg_oe,
	output vrc3_pkg::srm_addr_t  srm_addr,
	output logic                 srm_ce,
	output logic                 srm_oe,
	output logic                 srm_we,
	output vrc3_pkg::chr_addr_t  chr_addr,
	output logic                 chr_ce,
	output logic                 chr_oe,
	output logic                 chr_we,
	output logic                 ciram_a10,
	output logic                 ciram_ce,
	output logic                 map_cpu_oe,
	output vrc3_pkg::byte_t      map_cpu_do,
	output logic                 map_ppu_oe,
	output vrc3_pkg::byte_t      map_ppu_do,
	output vrc3_pkg::byte_t      sst_di,
	output logic                 irq
);
	import vrc3_pkg::*;

	logic [3:0] latch_we;
	logic       ctrl_we;
	logic       ack_we;
	nibble_t    wdata;
	nibble_t    prg_bank;
	irq_count_t reload;
	irq_count_t count;
	logic [2:0] irq_cfg;
	logic       irq_pend;

	vrc3_reg_decode vrc3_reg_decode_inst (
		.m2, .rst_n, .cpu_addr, .cpu_data, .cpu_rw,
		.sst_act, .sst_we_reg, .sst_addr, .sst_dato,
		.latch_we, .ctrl_we, .ack_we, .wdata, .prg_bank
	);

	vrc3_irq_timer vrc3_irq_timer_inst (
		.m2, .rst_n, .latch_we, .ctrl_we, .ack_we, .wdata,
		.sst_act, .sst_we_reg, .sst_addr, .sst_dato,
		.reload, .count, .irq_cfg, .irq_pend, .irq
	);

	vrc3_bank_map vrc3_bank_map_inst (
		.prg_bank, .cpu_addr, .cpu_rw, .ppu_addr, .ppu_oe, .ppu_we,
		.cfg_mir_v, .cfg_chr_ram, .prg_do, .srm_do, .chr_do,
		.prg_addr, .prg_ce, .prg_oe,
		.srm_addr, .srm_ce, .srm_oe, .srm_we,
		.chr_addr, .chr_ce, .chr_oe, .chr_we,
		.ciram_a10, .ciram_ce,
		.map_cpu_oe, .map_cpu_do, .map_ppu_oe, .map_ppu_do
	);

	vrc3_sst_port vrc3_sst_port_inst (
		.sst_addr, .prg_bank, .irq_pend, .irq_cfg,
		.reload, .count, .map_idx, .sst_di
	);

endmodule

`default_nettype wire

// ==== bench/vrc3_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module vrc3_tb;
	import vrc3_pkg::*;

	typedef enum int {OP_IDLE, OP_WR, OP_RD, OP_PPU, OP_SST_WR, OP_SST_RD, OP_WAIT} op_t;

	typedef struct packed {
		op_t       op;
		cpu_addr_t addr;   // CPU, PPU or save-state address.
		byte_t     data;   // For PPU rows: bit 0 mir_v, bit 1 chr_ram, bit 2 write.
		int        n;      // Edges of a wait row.
		prg_addr_t exp_prg;
		chr_addr_t exp_chr;
		byte_t     exp_byte;
		logic      exp_bit;
		logic      exp_bit2;
	} row_t;

	localparam byte_t MAP_NUM = 8'd73;

	logic       m2 = 1'b0;
	logic       rst_n;
	cpu_addr_t  cpu_addr;
	byte_t      cpu_data;
	logic       cpu_rw;
	ppu_addr_t  ppu_addr;
	logic       ppu_oe;
	logic       ppu_we;
	logic       cfg_mir_v;
	logic       cfg_chr_ram;
	byte_t      map_idx;
	logic       sst_act;
	logic       sst_we_reg;
	sst_addr_t  sst_addr;
	byte_t      sst_dato;
	byte_t      prg_do;
	byte_t      srm_do;
	byte_t      chr_do;
	prg_addr_t  prg_addr;
	logic       prg_ce;
	logic       prg_oe;
	srm_addr_t  srm_addr;
	logic       srm_ce;
	logic       srm_oe;
	logic       srm_we;
	chr_addr_t  chr_addr;
	logic       chr_ce;
	logic       chr_oe;
	logic       chr_we;
	logic       ciram_a10;
	logic       ciram_ce;
	logic       map_cpu_oe;
	byte_t      map_cpu_do;
	logic       map_ppu_oe;
	byte_t      map_ppu_do;
	byte_t      sst_di;
	logic       irq;

	row_t       rows[$];
	int         edges_total = 0;
	int         errors = 0;
	logic       table_ready = 1'b0;

	// Reference state of the mapper.
	nibble_t    m_bank;
	irq_count_t m_reload;
	irq_count_t m_count;
	logic       m_mode8;
	logic       m_on;
	logic       m_ack_on;
	logic       m_pend;

	vrc3_mapper vrc3_mapper_inst (.*);

	always #10 m2 = ~m2;   // 20 ns period.

	// Memory contents, every address bit folded in.
	function automatic byte_t prg_pattern(input prg_addr_t a);
		return a[7:0] ^ a[15:8] ^ {6'd0, a[17:16]} ^ 8'ha5;
	endfunction

	function automatic byte_t srm_pattern(input srm_addr_t a);
		return a[7:0] ^ {3'd0, a[12:8]} ^ 8'h3c;
	endfunction

	function automatic byte_t chr_pattern(input chr_addr_t a);
		return a[7:0] ^ {3'd0, a[12:8]} ^ 8'h5a;
	endfunction

	assign prg_do = prg_pattern(prg_addr);
	assign srm_do = srm_pattern(srm_addr);
	assign chr_do = chr_pattern(chr_addr);

	task automatic abort_run(input string why);
		errors++;
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, "Simulation stopped.");
	endtask

	task automatic check_byte(input string name, input byte_t got, input byte_t exp);
		if (got !== exp)
			abort_run($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic check_prg_addr(input string name, input prg_addr_t got, input prg_addr_t exp);
		if (got !== exp)
			abort_run($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic check_chr_addr(input string name, input chr_addr_t got, input chr_addr_t exp);
		if (got !== exp)
			abort_run($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("ERR %0t %s got %b expected %b", $time, name, got, exp));
	endtask

	function automatic logic in_srm(input cpu_addr_t a);
		return (a >= 16'h6000) && (a <= 16'h7fff);
	endfunction

	function automatic prg_addr_t model_prg_addr(input nibble_t bank, input cpu_addr_t a);
		nibble_t page;
		page = (a >= 16'hc000) ? 4'd15 : bank;   // Upper window is fixed.
		return prg_addr_t'(page) * 18'h4000 + prg_addr_t'(a & 16'h3fff);
	endfunction

	function automatic byte_t model_sst_read(input sst_addr_t idx);
		case (idx)
			8'd0: return {4'h0, m_bank};
			8'd1: return {4'h0, m_pend, m_mode8, m_on, m_ack_on};
			8'd2: return m_reload[15:8];
			8'd3: return m_reload[7:0];
			8'd4: return m_count[15:8];
			8'd5: return m_count[7:0];
			8'd127: return MAP_NUM;
			default: return 8'hff;
		endcase
	endfunction

	task automatic count_step();
		if (m_mode8)
		begin
			if (m_count[7:0] == 8'hff)
			begin
				m_count[7:0] = m_reload[7:0];
				m_pend = 1'b1;
			end
			else
				m_count[7:0] = m_count[7:0] + 8'd1;
		end
		else if (m_count == 16'hffff)
		begin
			m_count = m_reload;
			m_pend = 1'b1;
		end
		else
			m_count = m_count + 16'd1;
	endtask

	// One falling edge of m2 with the row's inputs applied.
	task automatic model_edge(input op_t op, input cpu_addr_t a, input byte_t d);
		logic was_on;
		was_on = m_on;
		if (op == OP_SST_WR)
		begin
			case (a[7:0])
				8'd0: m_bank = d[3:0];
				8'd1: {m_pend, m_mode8, m_on, m_ack_on} = d[3:0];
				8'd2: m_reload[15:8] = d;
				8'd3: m_reload[7:0] = d;
				8'd4: m_count[15:8] = d;
				8'd5: m_count[7:0] = d;
				default: ;
			endcase
		end
		else if (op != OP_SST_RD)
		begin
			if (op == OP_WR)
			begin
				case (a[15:12])
					4'h8: m_reload[3:0] = d[3:0];
					4'h9: m_reload[7:4] = d[3:0];
					4'ha: m_reload[11:8] = d[3:0];
					4'hb: m_reload[15:12] = d[3:0];
					4'hd:
					begin
						m_pend = 1'b0;
						m_on = m_ack_on;
					end
					4'hf: m_bank = d[3:0];
					default: ;
				endcase
			end
			if (op == OP_WR && a[15:12] == 4'hc)
			begin
				{m_mode8, m_on, m_ack_on} = d[2:0];
				m_pend = 1'b0;
				if (d[1])
					m_count = m_reload;
			end
			else if (was_on)
				count_step();   // A wrap wins over an acknowledge.
		end
	endtask

	// Expected values come from the model state before the row's edge.
	task automatic add_row(input op_t op, input cpu_addr_t a, input byte_t d, input int n);
		row_t r;
		r.op = op;
		r.addr = a;
		r.data = d;
		r.n = n;
		r.exp_prg = model_prg_addr(m_bank, a);
		r.exp_chr = chr_addr_t'(a & 16'h1fff);
		r.exp_byte = 8'h00;
		r.exp_bit = 1'b0;
		r.exp_bit2 = 1'b0;
		case (op)
			OP_WR: r.exp_bit = in_srm(a);
			OP_RD:
			begin
				r.exp_bit = in_srm(a);
				r.exp_byte = in_srm(a) ? srm_pattern(srm_addr_t'(a & 16'h1fff))
					: prg_pattern(r.exp_prg);
			end
			OP_PPU:
			begin
				r.exp_bit = d[1] && d[2] && (a < 16'h2000);
				r.exp_bit2 = d[0] ? a[10] : a[11];
				r.exp_byte = chr_pattern(r.exp_chr);
			end
			OP_SST_RD: r.exp_byte = model_sst_read(a[7:0]);
			default: ;
		endcase
		if (op == OP_WAIT)
		begin
			repeat (n) model_edge(OP_IDLE, a, d);
			r.exp_bit = m_pend;
			edges_total += n;
		end
		else
		begin
			model_edge(op, a, d);
			edges_total += 1;
		end
		rows.push_back(r);
	endtask

	task automatic build_table();
		integer  seed;
		int      r16;
		int      r8;
		byte_t   rnd_bank;
		cpu_addr_t rnd_ofs;
		byte_t   rnd_val;
		seed = 32'ha9a5;
		r16 = 16'hfff0;
		r8 = 8'hf0;
		{m_bank, m_reload, m_count} = '0;
		{m_mode8, m_on, m_ack_on, m_pend} = '0;
		for (int i = 0; i < 6; i++)
			add_row(OP_SST_RD, cpu_addr_t'(i), 8'h00, 0);   // Reset values.
		add_row(OP_WAIT, 16'h0000, 8'h00, 1);
		add_row(OP_WR, 16'hf000, 8'h03, 0);
		add_row(OP_RD, 16'h8123, 8'h00, 0);
		add_row(OP_RD, 16'hbfff, 8'h00, 0);
		add_row(OP_RD, 16'hc456, 8'h00, 0);
		add_row(OP_RD, 16'hffff, 8'h00, 0);
		add_row(OP_WR, 16'hfabc, 8'he9, 0);   // Upper data bits ignored.
		add_row(OP_RD, 16'h8000, 8'h00, 0);
		add_row(OP_RD, 16'he001, 8'h00, 0);
		add_row(OP_WR, 16'h6000, 8'h5a, 0);
		add_row(OP_RD, 16'h6abc, 8'h00, 0);
		add_row(OP_RD, 16'h7fff, 8'h00, 0);
		add_row(OP_PPU, 16'h0567, 8'h01, 0);
		add_row(OP_PPU, 16'h1234, 8'h04, 0);   // CHR ROM write.
		add_row(OP_PPU, 16'h1234, 8'h06, 0);   // CHR RAM write.
		add_row(OP_PPU, 16'h2400, 8'h06, 0);
		add_row(OP_PPU, 16'h2800, 8'h01, 0);
		add_row(OP_PPU, 16'h2800, 8'h00, 0);
		// 16-bit timer.
		add_row(OP_WR, 16'h8000, 8'h00, 0);
		add_row(OP_WR, 16'h9000, 8'h0f, 0);
		add_row(OP_WR, 16'ha000, 8'h0f, 0);
		add_row(OP_WR, 16'hb000, 8'h0f, 0);
		add_row(OP_SST_RD, 16'd2, 8'h00, 0);
		add_row(OP_SST_RD, 16'd3, 8'h00, 0);
		add_row(OP_WR, 16'hc000, 8'h02, 0);
		add_row(OP_WAIT, 16'h0000, 8'h00, 65535 - r16);
		add_row(OP_WAIT, 16'h0000, 8'h00, 1);
		add_row(OP_WR, 16'hd000, 8'h00, 0);
		add_row(OP_WAIT, 16'h0000, 8'h00, 1);
		add_row(OP_SST_RD, 16'd5, 8'h00, 0);
		add_row(OP_WAIT, 16'h0000, 8'h00, 3);
		add_row(OP_SST_RD, 16'd5, 8'h00, 0);
		// 8-bit timer and acknowledge.
		add_row(OP_WR, 16'h9000, 8'h0f, 0);
		add_row(OP_WR, 16'ha000, 8'h05, 0);
		add_row(OP_WR, 16'hb000, 8'h0a, 0);
		add_row(OP_WR, 16'hc000, 8'h06, 0);
		add_row(OP_WAIT, 16'h0000, 8'h00, 255 - r8);
		add_row(OP_WAIT, 16'h0000, 8'h00, 1);
		add_row(OP_SST_RD, 16'd4, 8'h00, 0);
		add_row(OP_WR, 16'hd000, 8'h00, 0);   // Stops, bit 0 was clear.
		add_row(OP_WAIT, 16'h0000, 8'h00, 1);
		add_row(OP_WR, 16'hc000, 8'h07, 0);
		add_row(OP_WAIT, 16'h0000, 8'h00, 255 - r8);
		add_row(OP_WAIT, 16'h0000, 8'h00, 1);
		add_row(OP_WR, 16'hd000, 8'h00, 0);   // Keeps counting.
		add_row(OP_WAIT, 16'h0000, 8'h00, 14);
		add_row(OP_WAIT, 16'h0000, 8'h00, 1);
		// Save-state round trip.
		add_row(OP_SST_WR, 16'd0, 8'h0b, 0);
		add_row(OP_SST_WR, 16'd1, 8'hf5, 0);
		add_row(OP_SST_WR, 16'd2, 8'h12, 0);
		add_row(OP_SST_WR, 16'd3, 8'h34, 0);
		add_row(OP_SST_WR, 16'd4, 8'h56, 0);
		add_row(OP_SST_WR, 16'd5, 8'h78, 0);
		for (int i = 0; i < 6; i++)
			add_row(OP_SST_RD, cpu_addr_t'(i), 8'h00, 0);
		add_row(OP_SST_RD, 16'd127, 8'h00, 0);
		add_row(OP_SST_RD, 16'd6, 8'h00, 0);
		add_row(OP_SST_RD, 16'h0080, 8'h00, 0);
		add_row(OP_RD, 16'h8004, 8'h00, 0);
		add_row(OP_SST_WR, 16'd1, 8'h06, 0);   // Running, but frozen in save state.
		repeat (3) add_row(OP_SST_RD, 16'd5, 8'h00, 0);
		add_row(OP_WAIT, 16'h0000, 8'h00, 1);
		add_row(OP_SST_RD, 16'd5, 8'h00, 0);
		for (int i = 0; i < 8; i++)
		begin
			rnd_bank = byte_t'($random(seed));
			rnd_ofs = cpu_addr_t'($random(seed));
			rnd_val = byte_t'($random(seed));
			add_row(OP_WR, REG_PRG_BANK, rnd_bank, 0);
			add_row(OP_RD, 16'h8000 | (rnd_ofs & 16'h3fff), 8'h00, 0);
			add_row(OP_SST_WR, 16'd3, rnd_val, 0);
			add_row(OP_SST_RD, 16'd3, 8'h00, 0);
		end
	endtask

	task automatic apply_row(input row_t r);
		@(posedge m2);
		cpu_addr <= 16'h4020;   // Idle, outside every decoded range.
		cpu_rw <= 1'b1;
		sst_act <= 1'b0;
		sst_we_reg <= 1'b0;
		ppu_oe <= 1'b1;
		ppu_we <= 1'b1;
		case (r.op)
			OP_WR:
			begin
				cpu_addr <= r.addr;
				cpu_data <= r.data;
				cpu_rw <= 1'b0;
			end
			OP_RD: cpu_addr <= r.addr;
			OP_PPU:
			begin
				ppu_addr <= r.addr[13:0];
				cfg_mir_v <= r.data[0];
				cfg_chr_ram <= r.data[1];
				ppu_we <= !r.data[2];
				ppu_oe <= r.data[2];
			end
			OP_SST_WR, OP_SST_RD:
			begin
				sst_act <= 1'b1;
				sst_we_reg <= (r.op == OP_SST_WR);
				sst_addr <= r.addr[7:0];
				sst_dato <= r.data;
			end
			default: ;
		endcase
		#5;
		case (r.op)
			OP_WR:
			begin
				check_bit("srm_we", srm_we, 1'b1);
				check_bit("srm_ce", srm_ce, r.exp_bit);
				check_bit("prg_ce", prg_ce, r.addr >= 16'h8000);
				check_bit("prg_oe", prg_oe, 1'b0);
				check_bit("srm_oe", srm_oe, 1'b0);
				check_bit("map_cpu_oe", map_cpu_oe, 1'b0);   // No read data on a write.
			end
			OP_RD:
			begin
				check_bit("srm_ce", srm_ce, r.exp_bit);
				check_bit("srm_we", srm_we, 1'b0);
				check_bit("prg_ce", prg_ce, r.addr >= 16'h8000);
				check_bit("prg_oe", prg_oe, 1'b1);
				check_bit("srm_oe", srm_oe, 1'b1);
				check_bit("map_cpu_oe", map_cpu_oe, r.addr >= 16'h6000);
				if (r.addr >= 16'h8000)
					check_prg_addr("prg_addr", prg_addr, r.exp_prg);
				check_byte("map_cpu_do", map_cpu_do, r.exp_byte);
			end
			OP_PPU:
			begin
				check_chr_addr("chr_addr", chr_addr, r.exp_chr);
				check_bit("chr_ce", chr_ce, r.addr < 16'h2000);
				check_bit("chr_oe", chr_oe, !r.data[2]);
				check_bit("chr_we", chr_we, r.exp_bit);
				check_bit("map_ppu_oe", map_ppu_oe, !r.data[2] && r.addr < 16'h2000);
				check_bit("ciram_a10", ciram_a10, r.exp_bit2);
				check_bit("ciram_ce", ciram_ce, r.addr < 16'h2000);   // Active low.
				if (!r.data[2] && r.addr < 16'h2000)
					check_byte("map_ppu_do", map_ppu_do, r.exp_byte);
			end
			OP_SST_RD: check_byte("sst_di", sst_di, r.exp_byte);
			OP_WAIT: check_bit("map_cpu_oe", map_cpu_oe, 1'b0);   // Idle address.
			default: ;
		endcase
		if (r.op == OP_WAIT)
		begin
			repeat (r.n) @(negedge m2);
			#1;
			check_bit("irq", irq, r.exp_bit);
		end
		else
			@(negedge m2);
	endtask

	// Watchdog sized from the table.
	initial
	begin
		wait (table_ready);
		#((edges_total + 210) * 20);
		abort_run("Timeout: the test table did not finish in time.");
	end

	initial
	begin
		rst_n = 1'b0;
		cpu_addr = 16'h4020;
		cpu_data = 8'h00;
		cpu_rw = 1'b1;
		ppu_addr = 14'h3f00;
		ppu_oe = 1'b1;
		ppu_we = 1'b1;
		cfg_mir_v = 1'b0;
		cfg_chr_ram = 1'b0;
		map_idx = MAP_NUM;
		sst_act = 1'b0;
		sst_we_reg = 1'b0;
		sst_addr = 8'h00;
		sst_dato = 8'h00;
		build_table();
		table_ready = 1'b1;
		repeat (10) @(posedge m2);
		rst_n <= 1'b1;
		foreach (rows[i])
			apply_row(rows[i]);
		if (errors == 0)
		begin
			$display("Done: no errors");
			$finish;
		end
		else
			abort_run("Checks failed.");
	end

endmodule

`default_nettype wire

// ==== flist.f ====
src/vrc3_pkg.sv
src/vrc3_reg_decode.sv
src/vrc3_irq_timer.sv
src/vrc3_bank_map.sv
src/vrc3_sst_port.sv
src/vrc3_mapper.sv
bench/vrc3_tb.sv

// ==== Bender.yml ====
package:
  name: vrc3_mapper

sources:
  - src/vrc3_pkg.sv
  - src/vrc3_reg_decode.sv
  - src/vrc3_irq_timer.sv
  - src/vrc3_bank_map.sv
  - src/vrc3_sst_port.sv
  - src/vrc3_mapper.sv
  - target: simulation
    files:
      - bench/vrc3_tb.sv
